// File: bench/rom_loader_asserts.sv
// Bound into rom_loader_top; fail_count is read by the testbench at the end of the run
`default_nettype none

module rom_loader_asserts import loader_pkg::*; (
	input logic    clk_sys,
	input logic    reset,
	input logic    ioctl_wr,
	input byte_t   ioctl_index,
	input mem_wr_t mem_out
);

	int fail_count = 0;

	////////////////////////////// Write latency
	// Every memory write comes from a strobe two cycles back
	property p_wr_latency;
		@(posedge clk_sys) disable iff (reset)
			mem_out.wr |-> $past(ioctl_wr, 2);
	endproperty

	// Tape, disk and other indices never reach memory
	property p_other_index;
		@(posedge clk_sys) disable iff (reset)
			(ioctl_wr && ioctl_index != IDX_ROM && ioctl_index != IDX_EXT) |-> ##2 !mem_out.wr;
	endproperty

	property p_reset_clear;
		@(posedge clk_sys) reset |=> !mem_out.wr;
	endproperty

	////////////////////////////// Checks
	a_wr_latency: assert property (p_wr_latency) else begin
		$error("mem_out.wr without a strobe two cycles earlier");
		fail_count = fail_count + 1;
	end

	a_other_index: assert property (p_other_index) else begin
		$error("mem_out.wr after a strobe of a non-firmware index");
		fail_count = fail_count + 1;
	end

	a_reset_clear: assert property (p_reset_clear) else begin
		$error("mem_out.wr high in the cycle after reset");
		fail_count = fail_count + 1;
	end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// Free-running clk_sys of period 20 from time 0; reset is held for the first 2 rising edges only
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	localparam int HALF_PERIOD = 10;

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	// Power-on reset, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: bench/tb_rom_loader.sv
// Table-driven run of rom_loader_top; inputs change on falling edges, outputs are sampled there too
`default_nettype none

module tb_rom_loader import loader_pkg::*; ();

	localparam int NUM_ROWS = 16;
	localparam int DRAIN = 4;  // Idle cycles after a download

	typedef struct packed {
		byte_t       index;
		file_ext_t   ext;
		logic        model;
		logic        do_reset;  // Reset before the download
		ioctl_addr_t start;
		logic [15:0] count;
	} row_t;

	logic        clk_sys;
	logic        por;
	logic        row_reset;
	logic        reset;
	logic        ioctl_download;
	byte_t       ioctl_index;
	file_ext_t   ioctl_file_ext;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	byte_t       ioctl_dout;
	logic        model_sel;
	mem_wr_t     mem_out;
	rom_bitmap_t rom_map;

	row_t        rows [NUM_ROWS];
	mem_wr_t     exp_q0;  // Strobe driven this cycle
	mem_wr_t     exp_q1;
	rom_bitmap_t exp_map;
	page_t       exp_page;
	logic        exp_combo;
	logic        exp_model;
	integer      seed;
	int          limit_cycles = 0;
	int          value_errors;
	int          event_errors;
	int          map_errors;

	assign reset = por | row_reset;

	tb_clock i_clock (
		.clk_sys (clk_sys),
		.reset   (por)
	);

	rom_loader_top i_dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.model_sel      (model_sel),
		.mem_out        (mem_out),
		.rom_map        (rom_map)
	);

	bind rom_loader_top rom_loader_asserts i_asserts (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.mem_out     (mem_out)
	);

	////////////////////////////// Reference model
	function automatic int hex_value(input byte_t c);
		if (c >= "0" && c <= "9")
			return c - "0";
		if (c >= "A" && c <= "F")
			return c - "A" + 10;
		return -1;  // Not a hex digit
	endfunction

	task automatic decode_ext(input file_ext_t ext);
		int hi;
		int lo;
		hi = hex_value(ext[15:8]);
		lo = hex_value(ext[7:0]);
		exp_page = PAGE_MALFORMED;
		exp_combo = 1'b0;
		if (ext == "ZZ") begin
			exp_page = 9'h000;
		end else if (ext == "Z0") begin
			exp_page = 9'h000;
			exp_combo = 1'b1;
		end else begin
			if (hi >= 0)
				exp_page[7:4] = hi[3:0];
			if (lo >= 0)
				exp_page[3:0] = lo[3:0];
		end
	endtask

	task automatic predict(input ioctl_addr_t addr, input byte_t data, output mem_wr_t w);
		logic [10:0] slot;
		page_t       page;
		w = '0;
		w.data = data;
		slot = addr[24:14];
		if (ioctl_download && ioctl_index == IDX_ROM && slot < 11'd8) begin
			w.wr = 1'b1;
			w.bank = (slot >= 11'd4) ? 2'd1 : 2'd0;
			case (slot[1:0])
				2'd0: page = PAGE_OS;
				2'd1: page = PAGE_BASIC;
				2'd2: page = PAGE_AMSDOS;
				default: page = PAGE_MF2;
			endcase
			w.addr = {page, addr[13:0]};
		end else if (ioctl_download && ioctl_index == IDX_EXT) begin
			w.wr = 1'b1;
			w.bank = {1'b0, exp_model};
			w.addr = {exp_page[8], exp_page[7:0] + addr[21:14], addr[13:0]};
			if (exp_combo && addr[13:0] == 14'h3FFF) begin
				exp_page = PAGE_COMBO_NEXT;  // From the next write on
				exp_combo = 1'b0;
			end
		end
		if (w.wr && w.addr[22])
			exp_map[w.addr[21:14]] = 1'b1;
	endtask

	////////////////////////////// Checks
	task automatic check_mem(input mem_wr_t exp_w);
		if (exp_w.wr && mem_out.wr !== 1'b1) begin
			$display("Missing memory write, expected at address %h", exp_w.addr);
			event_errors = event_errors + 1;
		end else if (!exp_w.wr && mem_out.wr !== 1'b0) begin
			$display("Unexpected memory write at address %h", mem_out.addr);
			event_errors = event_errors + 1;
		end else if (exp_w.wr) begin
			if (mem_out.addr !== exp_w.addr) begin
				$display("ERR mem_out.addr got %h expected %h", mem_out.addr, exp_w.addr);
				value_errors = value_errors + 1;
			end
			if (mem_out.bank !== exp_w.bank) begin
				$display("ERR mem_out.bank got %h expected %h", mem_out.bank, exp_w.bank);
				value_errors = value_errors + 1;
			end
			if (mem_out.data !== exp_w.data) begin
				$display("ERR mem_out.data got %h expected %h", mem_out.data, exp_w.data);
				value_errors = value_errors + 1;
			end
		end
	endtask

	// One falling edge: check the write due now, then drive the next beat
	task automatic tick(input logic wr, input ioctl_addr_t addr, input byte_t data);
		mem_wr_t exp_now;
		@(negedge clk_sys);
		check_mem(exp_q1);
		exp_q1 = exp_q0;
		exp_now = '0;
		if (wr)
			predict(addr, data, exp_now);
		exp_q0 = exp_now;
		ioctl_wr = wr;
		ioctl_addr = addr;
		ioctl_dout = data;
	endtask

	task automatic load_table();
		rows[0]  = '{8'd0, 16'h0, 1'b0, 1'b1, 25'h0003FFE, 16'd4};  // Slot 0 to 1
		rows[1]  = '{8'd0, 16'h0, 1'b0, 1'b0, 25'h000BFFE, 16'd4};
		rows[2]  = '{8'd0, 16'h0, 1'b0, 1'b0, 25'h0013FFE, 16'd4};  // Second bank
		rows[3]  = '{8'd0, 16'h0, 1'b0, 1'b0, 25'h001BFFE, 16'd4};
		rows[4]  = '{8'd0, 16'h0, 1'b0, 1'b0, 25'h001FFFE, 16'd4};  // Into slot 8
		rows[5]  = '{8'd0, 16'h0, 1'b0, 1'b0, 25'h1000000, 16'd2};
		rows[6]  = '{8'd1, 16'h0, 1'b0, 1'b0, 25'h0000000, 16'd3};
		rows[7]  = '{8'd5, 16'h0, 1'b0, 1'b0, 25'h0004000, 16'd3};
		rows[8]  = '{8'd3, "3A",  1'b1, 1'b1, 25'h0000000, 16'd3};
		rows[9]  = '{8'd3, "3A",  1'b0, 1'b0, 25'h0317FFE, 16'd4};  // Wraps past FF
		rows[10] = '{8'd3, "3G",  1'b0, 1'b1, 25'h0000000, 16'd2};
		rows[11] = '{8'd3, "QQ",  1'b1, 1'b0, 25'h0004000, 16'd2};
		rows[12] = '{8'd3, "ZZ",  1'b0, 1'b0, 25'h0000000, 16'd2};
		rows[13] = '{8'd3, "Z0",  1'b1, 1'b1, 25'h0003FFE, 16'd4};
		rows[14] = '{8'd3, "Z0",  1'b1, 1'b0, 25'h000BFFE, 16'd3};
		rows[15] = '{8'd7, 16'h0, 1'b0, 1'b1, 25'h0000000, 16'd2};  // Map cleared
	endtask

	////////////////////////////// Watchdog
	initial begin
		wait (limit_cycles > 0);
		#(limit_cycles * 20);
		$display("Watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////// Main sequence
	initial begin
		int total;
		int r;
		int i;
		int rnd;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_file_ext = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		model_sel = 1'b0;
		row_reset = 1'b0;
		exp_q0 = '0;
		exp_q1 = '0;
		exp_map = '0;
		exp_page = PAGE_MALFORMED;
		exp_combo = 1'b0;
		exp_model = 1'b0;
		seed = 26;
		value_errors = 0;
		event_errors = 0;
		map_errors = 0;
		load_table();
		total = 0;
		for (r = 0; r < NUM_ROWS; r++)
			total = total + rows[r].count;
		limit_cycles = total + NUM_ROWS * (DRAIN + 12) + 50;

		wait (por == 1'b0);
		for (r = 0; r < NUM_ROWS; r++) begin
			model_sel = rows[r].model;  // Only taken while reset is high
			if (rows[r].do_reset) begin
				row_reset = 1'b1;
				tick(1'b0, '0, '0);
				tick(1'b0, '0, '0);
				row_reset = 1'b0;
				exp_model = rows[r].model;  // Latched while reset was high
				exp_map = '0;
			end
			ioctl_index = rows[r].index;
			ioctl_file_ext = rows[r].ext;
			ioctl_download = 1'b1;
			decode_ext(rows[r].ext);
			for (i = 0; i < rows[r].count; i++) begin
				rnd = $random(seed);
				tick(1'b1, rows[r].start + i, rnd[7:0]);
			end
			tick(1'b0, '0, '0);
			ioctl_download = 1'b0;
			repeat (DRAIN) tick(1'b0, '0, '0);
			if (rom_map !== exp_map) begin
				$display("ERR rom_map got %h expected %h", rom_map, exp_map);
				map_errors = map_errors + 1;
			end
		end

		total = value_errors + event_errors + map_errors + i_dut.i_asserts.fail_count;
		$display("Errors: value %0d, missing or unexpected %0d, map %0d, assertion %0d",
			value_errors, event_errors, map_errors, i_dut.i_asserts.fail_count);
		if (total == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpc_rom_loader.f
logic/loader_pkg.sv
logic/download_tracker.sv
logic/rom_addr_map.sv
logic/rom_map_tracker.sv
logic/rom_loader_top.sv
bench/tb_clock.sv
bench/rom_loader_asserts.sv
bench/tb_rom_loader.sv

// File: logic/download_tracker.sv
// Stage 1; ioctl_wr is a one-cycle strobe, file extension must be valid when download rises
`default_nettype none

module download_tracker import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  byte_t       ioctl_index,
	input  file_ext_t   ioctl_file_ext,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  byte_t       ioctl_dout,
	input  logic        model_sel,
	output dl_beat_t    beat
);

	dl_kind_t   kind;
	logic       download_d;  // Previous ioctl_download
	logic       ext_start;
	logic       combo_step;
	logic       combo;       // Z0 rule, first slot still pending
	logic       model;
	page_t      page;
	page_t      ext_page;
	logic       ext_combo;
	logic [4:0] hi_digit;
	logic [4:0] lo_digit;

	// Valid flag and value of one hex character
	function automatic logic [4:0] hex_digit(input byte_t c);
		logic [4:0] r;
		r = 5'b0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	////////////////////////////// Classify
	always_comb begin
		if (!ioctl_download)
			kind = DL_NONE;
		else if (ioctl_index == IDX_ROM)
			kind = DL_ROM;
		else if (ioctl_index == IDX_EXT)
			kind = DL_EXT;
		else
			kind = DL_NONE;  // Tape, disk and others
	end

	assign ext_start = (kind == DL_EXT) && !download_d;

	// Last byte of a 16 KB slot while the combo is armed
	assign combo_step = combo && ioctl_wr && (kind == DL_EXT) &&
		(&ioctl_addr[SLOT_BITS-1:0]);

	////////////////////////////// Extension decode
	assign hi_digit = hex_digit(ioctl_file_ext[15:8]);
	assign lo_digit = hex_digit(ioctl_file_ext[7:0]);

	always_comb begin
		ext_page = PAGE_MALFORMED;
		ext_combo = 1'b0;
		// Each good digit replaces its own nibble
		if (hi_digit[4])
			ext_page[7:4] = hi_digit[3:0];
		if (lo_digit[4])
			ext_page[3:0] = lo_digit[3:0];
		if (ioctl_file_ext == "ZZ")
			ext_page = '0;  // Lower half page 0
		if (ioctl_file_ext == "Z0") begin
			ext_page = '0;
			ext_combo = 1'b1;
		end
	end

	////////////////////////////// Page and combo state
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			combo <= 1'b0;
			model <= model_sel;  // Machine model follows the switch during reset
		end else begin
			download_d <= ioctl_download;
			if (ext_start) begin
				page <= ext_page;
				combo <= ext_combo;
			end else if (combo_step) begin
				page <= PAGE_COMBO_NEXT;  // Current write still uses the old page
				combo <= 1'b0;
			end
		end
	end

	////////////////////////////// Beat register
	always_ff @(posedge clk_sys) begin
		beat.kind <= kind;
		beat.addr <= ioctl_addr;
		beat.data <= ioctl_dout;
		beat.page <= page;
		beat.model <= model;
		if (reset)
			beat.wr <= 1'b0;
		else
			beat.wr <= ioctl_wr;
	end

endmodule

`default_nettype wire

// File: logic/loader_pkg.sv
// Shared types and page constants for the ROM loader; 8 MB memory map split in two 4 MB halves
`default_nettype none

package loader_pkg;

	////////////////////////////// Widths
	typedef logic [24:0]  ioctl_addr_t;  // Host byte address
	typedef logic [22:0]  mem_addr_t;    // Bit 22 half, 21:14 page, 13:0 offset
	typedef logic [8:0]   page_t;        // Top bit selects upper half
	typedef logic [1:0]   bank_t;
	typedef logic [7:0]   byte_t;
	typedef logic [15:0]  file_ext_t;    // First character in upper byte
	typedef logic [255:0] rom_bitmap_t;  // One bit per upper-half page

	////////////////////////////// Download indices
	localparam byte_t IDX_ROM = 8'd0;  // Firmware image
	localparam byte_t IDX_EXT = 8'd3;  // Expansion ROM

	// Offset width inside one 16 KB page
	localparam int SLOT_BITS = 14;

	////////////////////////////// Fixed pages
	localparam page_t PAGE_OS     = 9'h000;
	localparam page_t PAGE_BASIC  = 9'h100;
	localparam page_t PAGE_AMSDOS = 9'h107;
	localparam page_t PAGE_MF2    = 9'h0FF;

	// Unused upper page for a bad extension
	localparam page_t PAGE_MALFORMED  = 9'h1EE;
	localparam page_t PAGE_COMBO_NEXT = 9'h1FF;  // Base for combo slots after the first

	// Valid 16 KB slots in a ROM image, two banks of four
	localparam int ROM_SLOTS = 8;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_ROM,
		DL_EXT
	} dl_kind_t;

	// Registered host beat out of stage 1
	typedef struct packed {
		logic        wr;
		dl_kind_t    kind;
		ioctl_addr_t addr;
		byte_t       data;
		page_t       page;   // Expansion base page
		logic        model;  // Latched at last reset
	} dl_beat_t;

	// Memory write into the SDRAM side
	typedef struct packed {
		logic      wr;
		mem_addr_t addr;
		bank_t     bank;
		byte_t     data;
	} mem_wr_t;

endpackage

`default_nettype wire

// File: logic/rom_addr_map.sv
// Stage 2; ROM slots past the eighth and beats outside a ROM or expansion download are dropped
`default_nettype none

module rom_addr_map import loader_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  dl_beat_t beat,
	output mem_wr_t  mem_out
);

	logic [10:0] slot;      // 16 KB slot in the ROM image
	mem_wr_t     mem_next;

	assign slot = beat.addr[24:SLOT_BITS];

	////////////////////////////// Address map
	// Lower half holds OS, RAM pages and MF2, upper half the expansion ROMs
	always_comb begin
		mem_next.wr = 1'b0;
		mem_next.addr = '1;
		mem_next.addr[SLOT_BITS-1:0] = beat.addr[SLOT_BITS-1:0];
		mem_next.bank = '0;
		mem_next.data = beat.data;

		case (beat.kind)
			DL_ROM: begin
				if (slot < ROM_SLOTS) begin
					mem_next.wr = beat.wr;
					mem_next.bank = {1'b0, slot[2]};  // 6128 set, then 664 set
					case (slot[1:0])
						2'd0:    mem_next.addr[22:SLOT_BITS] = PAGE_OS;
						2'd1:    mem_next.addr[22:SLOT_BITS] = PAGE_BASIC;
						2'd2:    mem_next.addr[22:SLOT_BITS] = PAGE_AMSDOS;
						default: mem_next.addr[22:SLOT_BITS] = PAGE_MF2;
					endcase
				end
			end

			DL_EXT: begin
				mem_next.wr = beat.wr;
				mem_next.addr[22] = beat.page[8];
				// Multi-slot files step through pages, wrapping in the half
				mem_next.addr[21:SLOT_BITS] = beat.page[7:0] + beat.addr[21:SLOT_BITS];
				mem_next.bank = {1'b0, beat.model};
			end

			default: mem_next.wr = 1'b0;  // Not a firmware download
		endcase
	end

	////////////////////////////// Write register
	always_ff @(posedge clk_sys) begin
		mem_out.addr <= mem_next.addr;
		mem_out.bank <= mem_next.bank;
		mem_out.data <= mem_next.data;
		if (reset)
			mem_out.wr <= 1'b0;
		else
			mem_out.wr <= mem_next.wr;
	end

endmodule

`default_nettype wire

// File: logic/rom_loader_top.sv
// Three-stage loader, one cycle per stage; no back-pressure so every host strobe is taken
`default_nettype none

module rom_loader_top import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  byte_t       ioctl_index,
	input  file_ext_t   ioctl_file_ext,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  byte_t       ioctl_dout,
	input  logic        model_sel,
	output mem_wr_t     mem_out,
	output rom_bitmap_t rom_map
);

	dl_beat_t beat;  // Stage 1 to stage 2

	////////////////////////////// Host side
	download_tracker i_tracker (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.model_sel      (model_sel),
		.beat           (beat)
	);

	////////////////////////////// Memory side
	rom_addr_map i_addr_map (
		.clk_sys (clk_sys),
		.reset   (reset),
		.beat    (beat),
		.mem_out (mem_out)
	);

	// Tracks the same writes that leave the top
	rom_map_tracker i_map_tracker (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mem_in  (mem_out),
		.rom_map (rom_map)
	);

endmodule

`default_nettype wire

// File: logic/rom_map_tracker.sv
// Stage 3; map bits only ever set until the next reset, lower-half writes are ignored
`default_nettype none

module rom_map_tracker import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  mem_wr_t     mem_in,
	output rom_bitmap_t rom_map
);

	logic       upper_wr;  // Write into the expansion half
	logic [7:0] upper_page;

	assign upper_wr = mem_in.wr && mem_in.addr[22];
	assign upper_page = mem_in.addr[21:SLOT_BITS];

	////////////////////////////// Loaded page map
	always_ff @(posedge clk_sys) begin
		if (reset)
			rom_map <= '0;
		else if (upper_wr)
			rom_map[upper_page] <= 1'b1;  // Page now holds a ROM
	end

endmodule

`default_nettype wire
